//--- Bender.yml
package:
  name: fv_bank

export_include_dirs:
  - design

sources:
  - design/fv_req_pkg.sv
  - design/fv_bank_pkg.sv
  - design/fv_req_router.sv
  - design/fv_bank.sv
  - design/fv_read_merge.sv
  - design/fv_bank_top.sv
  - target: test
    files:
      - bench/fv_bank_assertions.sv
      - bench/fv_bank_tb.sv

//--- bench/fv_bank_assertions.sv
`timescale 1ns/1ns
`include "fv_consts.svh"

module fv_bank_assertions (
    input logic                     clk,
    input logic                     reset,
    input logic                     rd_valid,
    input logic                     rd_eos,
    input logic [`FV_NUM_BANKS-1:0] bank_valid,
    input logic [`FV_NUM_BANKS-1:0] bank_sos,
    input logic [`FV_NUM_BANKS-1:0] bank_eos
);

    // each bank raises its framing markers only on a valid line
    a_marker_needs_valid: assert property (
        @(posedge clk) disable iff (reset)
        ((bank_sos | bank_eos) & ~bank_valid) == '0
    ) else $error("a bank raised sos or eos while its read valid is low");

    // merger assumes one streaming bank at a time
    a_single_bank: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(bank_valid)
    ) else $error("more than one bank drives read valid");

    // no gap between sos and eos
    a_no_gap: assert property (
        @(posedge clk) disable iff (reset)
        (rd_valid && !rd_eos) |=> rd_valid
    ) else $error("rd_valid dropped inside a read stream");

endmodule

//--- bench/fv_bank_tb.sv
`timescale 1ns/1ns
`include "fv_consts.svh"

module fv_bank_tb
    import fv_req_pkg::*, fv_bank_pkg::*;
();

    localparam int NUM_NODES    = `FV_NUM_BANKS * `FV_NODES_PER_BANK;
    localparam int READ_TIMEOUT = 20;

    logic     clk;
    logic     reset;
    logic     req_valid;
    fv_op_t   op;
    node_id_t node_id;
    pe_tag_t  pe_tag;
    fv_num_t  fv_num;
    fv_line_t wr_data;
    logic     wr_eos;
    logic     rd_valid;
    logic     rd_sos;
    logic     rd_eos;
    fv_line_t rd_data;
    pe_tag_t  rd_pe_tag;

    // reference copy of every line written so far
    fv_line_t model [NUM_NODES][`FV_LINES_PER_NODE];
    bit       written [NUM_NODES][`FV_LINES_PER_NODE];

    fv_bank_top fv_bank_top_inst (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .op        (op),
        .node_id   (node_id),
        .pe_tag    (pe_tag),
        .fv_num    (fv_num),
        .wr_data   (wr_data),
        .wr_eos    (wr_eos),
        .rd_valid  (rd_valid),
        .rd_sos    (rd_sos),
        .rd_eos    (rd_eos),
        .rd_data   (rd_data),
        .rd_pe_tag (rd_pe_tag)
    );

    // framing checks on the merged stream and the per-bank streams
    bind fv_bank_top fv_bank_assertions fv_bank_assertions_inst (
        .clk        (clk),
        .reset      (reset),
        .rd_valid   (rd_valid),
        .rd_eos     (rd_eos),
        .bank_valid (bank_rd_valid),
        .bank_sos   (bank_rd_sos),
        .bank_eos   (bank_rd_eos)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic end_in_failure();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_error(input string why);
        $display("error at %0t ns: %s", $time, why);
        end_in_failure();
    endtask

    task automatic check_line(input string name, input fv_line_t exp, input fv_line_t act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_tag(input string name, input pe_tag_t exp, input pe_tag_t act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            end_in_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            end_in_failure();
        end
    endtask

    // two values per line, rounded up, never below one line
    function automatic int line_count(input int num);
        int n;
        n = (num + 1) / 2;
        if (n < 1) begin
            n = 1;
        end
        return n;
    endfunction

    // first beat with the request, the rest on consecutive cycles
    task automatic run_write(input int node, input fv_line_t words[$]);
        int k;
        @(posedge clk);
        req_valid <= 1'b1;
        op        <= OP_WRITE;
        node_id   <= node_id_t'(node);
        wr_data   <= words[0];
        wr_eos    <= (words.size() == 1);
        for (k = 1; k < words.size(); k++) begin
            @(posedge clk);
            req_valid <= 1'b0;
            wr_data   <= words[k];
            wr_eos    <= (k == words.size() - 1);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        wr_eos    <= 1'b0;
        // idle gap before the next request
        repeat (2) @(posedge clk);
    endtask

    // outputs are sampled at the falling edge, mid-cycle
    task automatic run_read(input int node, input int tag, input int num,
                            input fv_line_t exp[$]);
        int n_lines;
        int waited;
        int k;
        n_lines = line_count(num);
        @(posedge clk);
        req_valid <= 1'b1;
        op        <= OP_READ;
        node_id   <= node_id_t'(node);
        pe_tag    <= pe_tag_t'(tag);
        fv_num    <= fv_num_t'(num);
        @(posedge clk);
        req_valid <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!rd_valid) begin
            // markers stay low before the stream
            check_bit("rd_sos", 1'b0, rd_sos);
            check_bit("rd_eos", 1'b0, rd_eos);
            waited++;
            if (waited > READ_TIMEOUT) begin
                report_error($sformatf("read of node %0d gave no data within %0d cycles",
                                       node, READ_TIMEOUT));
            end
            @(negedge clk);
        end
        for (k = 0; k < n_lines; k++) begin
            check_bit("rd_valid", 1'b1, rd_valid);
            check_bit("rd_sos", (k == 0), rd_sos);
            check_bit("rd_eos", (k == n_lines - 1), rd_eos);
            check_tag("rd_pe_tag", pe_tag_t'(tag), rd_pe_tag);
            check_line($sformatf("rd_data line %0d", k), exp[k], rd_data);
            @(negedge clk);
        end
        // no extra line after eos
        check_bit("rd_valid", 1'b0, rd_valid);
    endtask

    initial begin
        int               fd;
        int               c;
        int               code;
        int               node;
        int               cnt;
        int               tag;
        int               num;
        int               k;
        logic [31:0]      word;
        logic [8*256-1:0] rest;
        fv_line_t         words[$];

        reset     <= 1'b1;
        req_valid <= 1'b0;
        op        <= OP_WRITE;
        node_id   <= '0;
        pe_tag    <= '0;
        fv_num    <= '0;
        wr_data   <= '0;
        wr_eos    <= 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // quiet outputs with nothing requested
        repeat (4) begin
            @(negedge clk);
            check_bit("rd_valid", 1'b0, rd_valid);
            check_bit("rd_sos", 1'b0, rd_sos);
            check_bit("rd_eos", 1'b0, rd_eos);
        end

        fd = $fopen("bench/fv_stim.txt", "r");
        if (fd == 0) begin
            report_error("cannot open bench/fv_stim.txt");
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                code = $fgets(rest, fd);
            end else if (c == "W") begin
                code = $fscanf(fd, "%h %d", node, cnt);
                if (code != 2 || node >= NUM_NODES || cnt < 1 || cnt > `FV_LINES_PER_NODE) begin
                    report_error("malformed write command in stimulus file");
                end
                words.delete();
                for (k = 0; k < cnt; k++) begin
                    code = $fscanf(fd, "%h", word);
                    if (code != 1) begin
                        report_error("missing write data in stimulus file");
                    end
                    words.push_back(word);
                    model[node][k]   = word;
                    written[node][k] = 1'b1;
                end
                run_write(node, words);
            end else if (c == "R") begin
                code = $fscanf(fd, "%h %h %d", node, tag, num);
                if (code != 3 || node >= NUM_NODES || num > `FV_MAX_FV_NUM) begin
                    report_error("malformed read command in stimulus file");
                end
                words.delete();
                for (k = 0; k < line_count(num); k++) begin
                    code = $fscanf(fd, "%h", word);
                    if (code != 1) begin
                        report_error("missing expected data in stimulus file");
                    end
                    // file must agree with what was actually written
                    if (!written[node][k]) begin
                        report_error("stimulus reads a line that was never written");
                    end
                    if (model[node][k] !== word) begin
                        report_error("stimulus expected value disagrees with written data");
                    end
                    words.push_back(word);
                end
                run_read(node, tag, num, words);
            end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                report_error("unknown command in stimulus file");
            end
            c = $fgetc(fd);
        end
        $fclose(fd);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- bench/fv_stim.txt
# W node(hex) lines(dec) data(hex)...   write node, one data word per line
# R node(hex) tag(hex) fv_num(dec) expected(hex)...   read, ceil(fv_num/2) words
W 05 8 a0010000 a0010001 a0010002 a0010003 a0010004 a0010005 a0010006 a0010007
W 09 3 b0020000 b0020001 b0020002
W 02 1 c0030000
W 03 4 d0040000 d0040001 d0040002 d0040003
W 00 2 e0050000 e0050001
R 05 1 16 a0010000 a0010001 a0010002 a0010003 a0010004 a0010005 a0010006 a0010007
R 09 2 5 b0020000 b0020001 b0020002
R 02 3 1 c0030000
R 03 0 7 d0040000 d0040001 d0040002 d0040003
R 00 2 3 e0050000 e0050001
# rewrite node 05, lines 2 to 7 keep the old data
W 05 2 f0060000 f0060001
R 05 3 4 f0060000 f0060001
R 05 1 16 f0060000 f0060001 a0010002 a0010003 a0010004 a0010005 a0010006 a0010007
R 09 0 6 b0020000 b0020001 b0020002
R 02 1 2 c0030000
R 03 2 8 d0040000 d0040001 d0040002 d0040003

//--- design/fv_bank.sv
`timescale 1ns/1ns
`include "fv_consts.svh"

module fv_bank
    import fv_req_pkg::*, fv_bank_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  fv_op_t     op,
    input  node_slot_t slot,
    input  pe_tag_t    tag,
    input  fv_num_t    fv_num,
    input  fv_line_t   wr_data,
    input  logic       wr_eos,
    output logic       rd_valid,
    output logic       rd_sos,
    output logic       rd_eos,
    output fv_line_t   rd_data,
    output pe_tag_t    rd_tag
);

    // line counter needs to reach 8
    localparam int CNT_W = `FV_LINE_IDX_BITS + 1;

    // slots times lines
    fv_line_t mem [`FV_NODES_PER_BANK][`FV_LINES_PER_NODE];

    bank_state_t      state, nx_state;
    logic [CNT_W-1:0] line_cnt, nx_line_cnt;
    node_slot_t       slot_q, nx_slot;
    fv_num_t          total_q, nx_total;
    pe_tag_t          tag_q, nx_tag;

    logic       wr_en;
    node_slot_t wr_slot;
    line_idx_t  wr_idx;
    logic       rd_en;
    node_slot_t rd_slot;
    line_idx_t  rd_idx;
    fv_line_t   mem_q;
    logic       nx_valid, nx_sos, nx_eos;
    logic       last_line;

    // last line once twice the count covers the feature count
    assign last_line = ({line_cnt, 1'b0} >= total_q);

    always_comb begin
        nx_state    = state;
        nx_line_cnt = line_cnt;
        nx_slot     = slot_q;
        nx_total    = total_q;
        nx_tag      = tag_q;
        wr_en       = 1'b0;
        wr_slot     = slot_q;
        wr_idx      = line_cnt[`FV_LINE_IDX_BITS-1:0];
        rd_en       = 1'b0;
        rd_slot     = slot_q;
        rd_idx      = line_cnt[`FV_LINE_IDX_BITS-1:0];
        nx_valid    = 1'b0;
        nx_sos      = 1'b0;
        nx_eos      = 1'b0;
        case (state)
            ST_IDLE: begin
                if (start) begin
                    nx_slot = slot;
                    wr_slot = slot;
                    rd_slot = slot;
                    wr_idx  = '0;
                    rd_idx  = '0;
                    if (op == OP_WRITE) begin
                        // first beat rides with the request
                        wr_en = 1'b1;
                        if (!wr_eos) begin
                            nx_state    = ST_WRITE;
                            nx_line_cnt = CNT_W'(1);
                        end
                    end else begin
                        // fetch line 0 now, framing starts next cycle
                        rd_en       = 1'b1;
                        nx_total    = fv_num;
                        nx_tag      = tag;
                        nx_line_cnt = CNT_W'(1);
                        nx_state    = ST_READ;
                    end
                end
            end
            ST_WRITE: begin
                wr_en       = 1'b1;
                nx_line_cnt = line_cnt + 1'b1;
                if (wr_eos) begin
                    nx_state    = ST_IDLE;
                    nx_line_cnt = '0;
                end
            end
            ST_READ: begin
                // mem_q holds line line_cnt-1 here
                nx_valid = 1'b1;
                nx_sos   = (line_cnt == CNT_W'(1));
                if (last_line) begin
                    nx_eos      = 1'b1;
                    nx_state    = ST_IDLE;
                    nx_line_cnt = '0;
                end else begin
                    rd_en       = 1'b1;
                    nx_line_cnt = line_cnt + 1'b1;
                end
            end
            default: nx_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            line_cnt <= '0;
            rd_valid <= 1'b0;
            rd_sos   <= 1'b0;
            rd_eos   <= 1'b0;
        end else begin
            state    <= nx_state;
            line_cnt <= nx_line_cnt;
            rd_valid <= nx_valid;
            rd_sos   <= nx_sos;
            rd_eos   <= nx_eos;
        end
    end

    // latched request fields and output payload
    always_ff @(posedge clk) begin
        slot_q  <= nx_slot;
        total_q <= nx_total;
        tag_q   <= nx_tag;
        rd_data <= mem_q;
        rd_tag  <= tag_q;
    end

    // line storage, synchronous read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_slot][wr_idx] <= wr_data;
        end
        if (rd_en) begin
            mem_q <= mem[rd_slot][rd_idx];
        end
    end

endmodule

//--- design/fv_bank_pkg.sv
`include "fv_consts.svh"

// bank side types for storage and bank control
package fv_bank_pkg;

    // bank controller states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_WRITE = 2'd1,
        ST_READ  = 2'd2
    } bank_state_t;

    // one storage line, two packed feature values
    typedef logic [`FV_LINE_WIDTH-1:0] fv_line_t;

    // node slot inside one bank
    typedef logic [`FV_SLOT_BITS-1:0] node_slot_t;

    // line index within a node
    typedef logic [`FV_LINE_IDX_BITS-1:0] line_idx_t;

endpackage

//--- design/fv_bank_top.sv
`timescale 1ns/1ns
`include "fv_consts.svh"

module fv_bank_top
    import fv_req_pkg::*, fv_bank_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     req_valid,
    input  fv_op_t   op,
    input  node_id_t node_id,
    input  pe_tag_t  pe_tag,
    input  fv_num_t  fv_num,
    input  fv_line_t wr_data,
    input  logic     wr_eos,
    output logic     rd_valid,
    output logic     rd_sos,
    output logic     rd_eos,
    output fv_line_t rd_data,
    output pe_tag_t  rd_pe_tag
);

    // router to banks, all broadcast except the start strobe
    logic [`FV_NUM_BANKS-1:0] bank_start;
    fv_op_t                   bank_op;
    node_slot_t               bank_slot;
    pe_tag_t                  bank_tag;
    fv_num_t                  bank_fv_num;
    fv_line_t                 bank_wr_data;
    logic                     bank_wr_eos;

    // banks to merger
    logic [`FV_NUM_BANKS-1:0] bank_rd_valid;
    logic [`FV_NUM_BANKS-1:0] bank_rd_sos;
    logic [`FV_NUM_BANKS-1:0] bank_rd_eos;
    fv_line_t                 bank_rd_data [`FV_NUM_BANKS];
    pe_tag_t                  bank_rd_tag [`FV_NUM_BANKS];

    fv_req_router fv_req_router_inst (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .op           (op),
        .node_id      (node_id),
        .pe_tag       (pe_tag),
        .fv_num       (fv_num),
        .wr_data      (wr_data),
        .wr_eos       (wr_eos),
        .bank_start   (bank_start),
        .bank_op      (bank_op),
        .bank_slot    (bank_slot),
        .bank_tag     (bank_tag),
        .bank_fv_num  (bank_fv_num),
        .bank_wr_data (bank_wr_data),
        .bank_wr_eos  (bank_wr_eos)
    );

    // one bank per low node id value
    for (genvar b = 0; b < `FV_NUM_BANKS; b++) begin : g_bank
        fv_bank fv_bank_inst (
            .clk      (clk),
            .reset    (reset),
            .start    (bank_start[b]),
            .op       (bank_op),
            .slot     (bank_slot),
            .tag      (bank_tag),
            .fv_num   (bank_fv_num),
            .wr_data  (bank_wr_data),
            .wr_eos   (bank_wr_eos),
            .rd_valid (bank_rd_valid[b]),
            .rd_sos   (bank_rd_sos[b]),
            .rd_eos   (bank_rd_eos[b]),
            .rd_data  (bank_rd_data[b]),
            .rd_tag   (bank_rd_tag[b])
        );
    end

    fv_read_merge fv_read_merge_inst (
        .clk        (clk),
        .reset      (reset),
        .bank_valid (bank_rd_valid),
        .bank_sos   (bank_rd_sos),
        .bank_eos   (bank_rd_eos),
        .bank_data  (bank_rd_data),
        .bank_tag   (bank_rd_tag),
        .rd_valid   (rd_valid),
        .rd_sos     (rd_sos),
        .rd_eos     (rd_eos),
        .rd_data    (rd_data),
        .rd_pe_tag  (rd_pe_tag)
    );

endmodule

//--- design/fv_consts.svh
`ifndef FV_CONSTS_SVH
`define FV_CONSTS_SVH

// bank geometry
`define FV_NUM_BANKS       4
`define FV_NODES_PER_BANK  16
`define FV_LINES_PER_NODE  8

// one line carries two feature values
`define FV_LINE_WIDTH      32
`define FV_MAX_FV_NUM      16

// edge processing elements fed by the read stream
`define FV_NUM_EDGE_PE     4

// derived field widths
`define FV_BANK_SEL_BITS   $clog2(`FV_NUM_BANKS)
`define FV_SLOT_BITS       $clog2(`FV_NODES_PER_BANK)
`define FV_LINE_IDX_BITS   $clog2(`FV_LINES_PER_NODE)
`define FV_NODE_ID_BITS    (`FV_BANK_SEL_BITS + `FV_SLOT_BITS)
`define FV_TAG_BITS        $clog2(`FV_NUM_EDGE_PE)
// one extra bit so the full count of 16 fits
`define FV_FV_NUM_BITS     ($clog2(`FV_MAX_FV_NUM) + 1)

`endif

//--- design/fv_read_merge.sv
`timescale 1ns/1ns
`include "fv_consts.svh"

module fv_read_merge
    import fv_req_pkg::*, fv_bank_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`FV_NUM_BANKS-1:0] bank_valid,
    input  logic [`FV_NUM_BANKS-1:0] bank_sos,
    input  logic [`FV_NUM_BANKS-1:0] bank_eos,
    input  fv_line_t                 bank_data [`FV_NUM_BANKS],
    input  pe_tag_t                  bank_tag [`FV_NUM_BANKS],
    output logic                     rd_valid,
    output logic                     rd_sos,
    output logic                     rd_eos,
    output fv_line_t                 rd_data,
    output pe_tag_t                  rd_pe_tag
);

    logic [`FV_BANK_SEL_BITS-1:0] sel;
    logic                         any_valid;

    assign any_valid = |bank_valid;

    // scan downward so the lowest valid index wins
    always_comb begin
        sel = '0;
        for (int i = `FV_NUM_BANKS - 1; i >= 0; i--) begin
            if (bank_valid[i]) begin
                sel = `FV_BANK_SEL_BITS'(i);
            end
        end
    end

    // framing is cleared while no bank streams
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
            rd_sos   <= 1'b0;
            rd_eos   <= 1'b0;
        end else begin
            rd_valid <= any_valid;
            rd_sos   <= any_valid & bank_sos[sel];
            rd_eos   <= any_valid & bank_eos[sel];
        end
    end

    always_ff @(posedge clk) begin
        rd_data   <= bank_data[sel];
        rd_pe_tag <= bank_tag[sel];
    end

endmodule

//--- design/fv_req_pkg.sv
`include "fv_consts.svh"

// request side types seen by the requester and the router
package fv_req_pkg;

    // request opcode
    typedef enum logic [0:0] {
        OP_WRITE = 1'b0,
        OP_READ  = 1'b1
    } fv_op_t;

    // global node id
    // low bits select the bank, upper bits the slot in it
    typedef logic [`FV_NODE_ID_BITS-1:0] node_id_t;

    // edge PE tag returned with every read line
    typedef logic [`FV_TAG_BITS-1:0] pe_tag_t;

    // feature count of a node, 0 to 16
    typedef logic [`FV_FV_NUM_BITS-1:0] fv_num_t;

endpackage

//--- design/fv_req_router.sv
`timescale 1ns/1ns
`include "fv_consts.svh"

module fv_req_router
    import fv_req_pkg::*, fv_bank_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  fv_op_t                   op,
    input  node_id_t                 node_id,
    input  pe_tag_t                  pe_tag,
    input  fv_num_t                  fv_num,
    input  fv_line_t                 wr_data,
    input  logic                     wr_eos,
    output logic [`FV_NUM_BANKS-1:0] bank_start,
    output fv_op_t                   bank_op,
    output node_slot_t               bank_slot,
    output pe_tag_t                  bank_tag,
    output fv_num_t                  bank_fv_num,
    output fv_line_t                 bank_wr_data,
    output logic                     bank_wr_eos
);

    logic [`FV_BANK_SEL_BITS-1:0] bank_sel;
    logic [`FV_NUM_BANKS-1:0]     nx_start;

    // bank from the low node id bits
    assign bank_sel = node_id[`FV_BANK_SEL_BITS-1:0];

    // one-hot strobe, only on the first beat
    always_comb begin
        nx_start = '0;
        if (req_valid) begin
            nx_start[bank_sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_start  <= '0;
            bank_wr_eos <= 1'b0;
        end else begin
            bank_start  <= nx_start;
            bank_wr_eos <= wr_eos;
        end
    end

    // request fields follow the strobe by the same one cycle
    // later write beats take this path too, so data stays aligned
    always_ff @(posedge clk) begin
        bank_op      <= op;
        bank_slot    <= node_id[`FV_NODE_ID_BITS-1 -: `FV_SLOT_BITS];
        bank_tag     <= pe_tag;
        bank_fv_num  <= fv_num;
        bank_wr_data <= wr_data;
    end

endmodule

//--- filelist.f
+incdir+design
design/fv_req_pkg.sv
design/fv_bank_pkg.sv
design/fv_req_router.sv
design/fv_bank.sv
design/fv_read_merge.sv
design/fv_bank_top.sv
bench/fv_bank_assertions.sv
bench/fv_bank_tb.sv
